//--- source/rob_pkg.sv
package rob_pkg;

    // architectural register number
    localparam int reg_name_w = 5;

    // result and address widths of the core
    localparam int data_w = 32;
    localparam int addr_w = 32;

    typedef logic [reg_name_w-1:0] reg_name_t;
    typedef logic [data_w-1:0]     data_t;
    typedef logic [addr_w-1:0]     addr_t;

    // commit controller states
    //   run           normal in-order retirement
    //   store_release head store handed to the store buffer
    //   store_wait    waiting for the store buffer to finish
    typedef enum logic [1:0] {
        run           = 2'd0,
        store_release = 2'd1,
        store_wait    = 2'd2
    } commit_state_t;

endpackage

//--- source/cdb_if.sv
`timescale 1ns/1ps

interface cdb_if #(
    parameter  int rob_depth = 8,
    localparam int tag_w     = $clog2(rob_depth)
);

    logic             valid;
    logic [tag_w-1:0] tag;
    rob_pkg::data_t   data;
    logic             taken;
    rob_pkg::addr_t   jump_pc;

    // execution side puts a result on the bus
    modport source (
        output valid, tag, data, taken, jump_pc
    );

    // reorder buffer picks it up by tag
    modport buffer (
        input valid, tag, data, taken, jump_pc
    );

endinterface

//--- source/rob_head_if.sv
`timescale 1ns/1ps

interface rob_head_if;

    // status of the oldest entry
    logic               valid;
    logic               done;
    logic               is_store;
    logic               mispredict;

    // payload needed at retirement
    rob_pkg::reg_name_t reg_name;
    rob_pkg::data_t     data;
    rob_pkg::addr_t     jump_pc;

    modport source (
        output valid, done, is_store, mispredict,
        output reg_name, data, jump_pc
    );

    modport sink (
        input valid, done, is_store, mispredict,
        input reg_name, data, jump_pc
    );

endinterface

//--- source/rob_ptr_ctrl.sv
`timescale 1ns/1ps

module rob_ptr_ctrl #(
    parameter  int rob_depth = 8,
    localparam int tag_w     = $clog2(rob_depth)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             alloc,
    input  logic             retire,
    input  logic             flush,
    output logic [tag_w-1:0] head,
    output logic [tag_w-1:0] tail,
    output logic             full,
    output logic             empty
);

    // count needs one extra bit to hold rob_depth itself
    logic [tag_w:0] count;
    logic           alloc_ok;

    // no back-pressure, so an alloc while full just drops
    assign alloc_ok = alloc && !full;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // pointers wrap on their own since depth is a power of two
            if (alloc_ok) begin
                tail <= tail + 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            case ({alloc_ok, retire})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    assign full  = (count == rob_depth[tag_w:0]);
    assign empty = (count == '0);

endmodule

//--- source/rob_entry_file.sv
`timescale 1ns/1ps

module rob_entry_file #(
    parameter  int rob_depth = 8,
    localparam int tag_w     = $clog2(rob_depth)
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc,
    input  rob_pkg::reg_name_t alloc_reg,
    input  logic               alloc_is_store,
    input  logic               alloc_pred_taken,
    input  logic [tag_w-1:0]   tail,
    input  logic [tag_w-1:0]   head,
    input  logic               full,
    input  logic               retire,
    input  logic               flush,
    cdb_if.buffer              cdb,
    rob_head_if.source         hd
);

    // control bits per entry
    logic [rob_depth-1:0] valid;
    logic [rob_depth-1:0] done;

    // payload per entry
    logic [rob_depth-1:0] is_store;
    logic [rob_depth-1:0] pred_taken;
    logic [rob_depth-1:0] act_taken;
    rob_pkg::reg_name_t   reg_name [rob_depth];
    rob_pkg::data_t       data     [rob_depth];
    rob_pkg::addr_t       jump_pc  [rob_depth];

    logic                 alloc_ok;

    assign alloc_ok = alloc && !full;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid <= '0;
            done  <= '0;
        end else begin
            if (retire) begin
                valid[head] <= 1'b0;
                done[head]  <= 1'b0;
            end
            // tail never equals head here unless the buffer is empty
            if (alloc_ok) begin
                valid[tail] <= 1'b1;
                done[tail]  <= 1'b0;
            end
            if (cdb.valid) begin
                done[cdb.tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_ok) begin
            is_store[tail]   <= alloc_is_store;
            pred_taken[tail] <= alloc_pred_taken;
            reg_name[tail]   <= alloc_reg;
        end
        if (cdb.valid) begin
            data[cdb.tag]      <= cdb.data;
            act_taken[cdb.tag] <= cdb.taken;
            jump_pc[cdb.tag]   <= cdb.jump_pc;
        end
    end

    // head readout
    assign hd.valid    = valid[head];
    assign hd.done     = done[head];
    assign hd.is_store = is_store[head];
    assign hd.reg_name = reg_name[head];
    assign hd.data     = data[head];
    assign hd.jump_pc  = jump_pc[head];

    // only meaningful once the branch has resolved
    assign hd.mispredict = valid[head] && done[head] &&
                           (pred_taken[head] != act_taken[head]);

endmodule

//--- source/rob_commit_fsm.sv
`timescale 1ns/1ps

module rob_commit_fsm (
    input  logic               clk,
    input  logic               rst,
    rob_head_if.sink           hd,
    input  logic               store_done,
    output logic               retire,
    output logic               commit_valid,
    output rob_pkg::reg_name_t commit_reg,
    output rob_pkg::data_t     commit_data,
    output logic               flush,
    output rob_pkg::addr_t     flush_pc,
    output logic               store_release
);

    rob_pkg::commit_state_t state;
    rob_pkg::commit_state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rob_pkg::run;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next    = state;
        retire        = 1'b0;
        commit_valid  = 1'b0;
        flush         = 1'b0;
        store_release = 1'b0;
        case (state)
            rob_pkg::run: begin
                if (hd.valid) begin
                    // stores skip completion and go to the store buffer
                    if (hd.is_store) begin
                        state_next = rob_pkg::store_release;
                    end else if (hd.done) begin
                        retire       = 1'b1;
                        commit_valid = 1'b1;
                        flush        = hd.mispredict;
                    end
                end
            end
            rob_pkg::store_release: begin
                store_release = 1'b1;
                state_next    = rob_pkg::store_wait;
            end
            rob_pkg::store_wait: begin
                // store leaves without a register write
                if (store_done) begin
                    retire     = 1'b1;
                    state_next = rob_pkg::run;
                end
            end
            default: begin
                state_next = rob_pkg::run;
            end
        endcase
    end

    // payload straight from the head entry
    assign commit_reg  = hd.reg_name;
    assign commit_data = hd.data;
    assign flush_pc    = hd.jump_pc;

endmodule

//--- source/rob_top.sv
`timescale 1ns/1ps

module rob_top #(
    parameter  int rob_depth = 8,
    localparam int tag_w     = $clog2(rob_depth)
) (
    input  logic               clk,
    input  logic               rst,
    // dispatch
    input  logic               alloc,
    input  rob_pkg::reg_name_t alloc_reg,
    input  logic               alloc_is_store,
    input  logic               alloc_pred_taken,
    output logic [tag_w-1:0]   alloc_tag,
    output logic               full,
    // completion bus
    input  logic               cdb_valid,
    input  logic [tag_w-1:0]   cdb_tag,
    input  rob_pkg::data_t     cdb_data,
    input  logic               cdb_taken,
    input  rob_pkg::addr_t     cdb_jump_pc,
    // retirement
    output logic               commit_valid,
    output logic [tag_w-1:0]   commit_tag,
    output rob_pkg::reg_name_t commit_reg,
    output rob_pkg::data_t     commit_data,
    output logic               flush,
    output rob_pkg::addr_t     flush_pc,
    output logic               store_release,
    output logic [tag_w-1:0]   store_tag,
    input  logic               store_done
);

    logic [tag_w-1:0] head;
    logic [tag_w-1:0] tail;
    logic             retire;

    cdb_if #(.rob_depth(rob_depth)) cdb ();
    rob_head_if                     hd ();

    assign cdb.valid   = cdb_valid;
    assign cdb.tag     = cdb_tag;
    assign cdb.data    = cdb_data;
    assign cdb.taken   = cdb_taken;
    assign cdb.jump_pc = cdb_jump_pc;

    // tags come straight from the pointers
    assign alloc_tag  = tail;
    assign commit_tag = head;
    assign store_tag  = head;

    rob_ptr_ctrl #(.rob_depth(rob_depth)) u_ptr (
        .clk    (clk),
        .rst    (rst),
        .alloc  (alloc),
        .retire (retire),
        .flush  (flush),
        .head   (head),
        .tail   (tail),
        .full   (full),
        .empty  ()
    );

    rob_entry_file #(.rob_depth(rob_depth)) u_entries (
        .clk              (clk),
        .rst              (rst),
        .alloc            (alloc),
        .alloc_reg        (alloc_reg),
        .alloc_is_store   (alloc_is_store),
        .alloc_pred_taken (alloc_pred_taken),
        .tail             (tail),
        .head             (head),
        .full             (full),
        .retire           (retire),
        .flush            (flush),
        .cdb              (cdb.buffer),
        .hd               (hd.source)
    );

    rob_commit_fsm u_commit (
        .clk           (clk),
        .rst           (rst),
        .hd            (hd.sink),
        .store_done    (store_done),
        .retire        (retire),
        .commit_valid  (commit_valid),
        .commit_reg    (commit_reg),
        .commit_data   (commit_data),
        .flush         (flush),
        .flush_pc      (flush_pc),
        .store_release (store_release)
    );

endmodule

//--- tests/rob_tb.sv
`timescale 1ns/1ps

module rob_tb;

    localparam int op_idle     = 0;
    localparam int op_alloc    = 1;
    localparam int op_complete = 2;
    localparam int op_sdone    = 3;
    localparam int op_wait     = 4;

    typedef struct {
        int          op;
        logic [4:0]  rd;
        logic        st;
        logic        tk;
        int          tag;
        string       name;
    } row_t;

    logic clk, rst, alloc, alloc_is_store, alloc_pred_taken, full;
    logic [4:0] alloc_reg, commit_reg;
    logic [2:0] alloc_tag, cdb_tag, commit_tag, store_tag;
    logic cdb_valid, cdb_taken, commit_valid, flush, store_release, store_done;
    logic [31:0] cdb_data, cdb_jump_pc, commit_data, flush_pc;

    row_t rows[$];
    int errors = 0;
    logic [31:0] lfsr = 32'h4c8c5405;

    // reference model of the buffer
    int q[$];
    int m_tail = 0;
    int m_state = 0;
    logic m_done[8], m_store[8], m_pred[8], m_act[8];
    logic [4:0] m_reg[8];
    logic [31:0] m_data[8], m_pc[8];

    rob_top #(.rob_depth(8)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] next_word();
        logic [31:0] w;
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            w = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic logic [31:0] jump_target(int tag);
        return 32'h0000_8000 + 32'(tag * 4);
    endfunction

    task automatic add_row(int op, int rd, bit st, bit tk, int tag, string name);
        row_t r;
        r = '{op, rd[4:0], st, tk, tag, name};
        rows.push_back(r);
    endtask

    task automatic check_value(string name, string what, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("error %s %s: expected %0h, actual %0h", name, what, exp, act);
        end
    endtask

    task automatic apply_row(row_t r);
        logic [31:0] d;
        logic e_full, e_commit, e_flush, e_rel, e_retire;
        int h, nxt;
        @(posedge clk);
        #5;
        d = (r.op == op_complete) ? next_word() : 32'h0;
        alloc            = (r.op == op_alloc);
        alloc_reg        = r.rd;
        alloc_is_store   = r.st;
        alloc_pred_taken = r.tk;
        cdb_valid        = (r.op == op_complete);
        cdb_tag          = r.tag[2:0];
        cdb_data         = d;
        cdb_taken        = r.tk;
        cdb_jump_pc      = jump_target(r.tag);
        store_done       = (r.op == op_sdone);
        e_full = (q.size() == 8);
        {e_commit, e_flush, e_rel, e_retire} = 4'b0;
        h = (q.size() > 0) ? q[0] : 0;
        nxt = m_state;
        // 0 run, 1 store release, 2 store wait
        if (m_state == 0 && q.size() > 0) begin
            if (m_store[h]) begin
                nxt = 1;
            end else if (m_done[h]) begin
                {e_commit, e_retire} = 2'b11;
                e_flush = (m_pred[h] != m_act[h]);
            end
        end else if (m_state == 1) begin
            e_rel = 1'b1;
            nxt = 2;
        end else if (m_state == 2 && store_done) begin
            e_retire = 1'b1;
            nxt = 0;
        end
        #40;
        check_value(r.name, "alloc_tag", 32'(m_tail), alloc_tag);
        check_value(r.name, "full", e_full, full);
        check_value(r.name, "commit_valid", e_commit, commit_valid);
        check_value(r.name, "flush", e_flush, flush);
        check_value(r.name, "store_release", e_rel, store_release);
        if (e_commit) begin
            check_value(r.name, "commit_tag", 32'(h), commit_tag);
            check_value(r.name, "commit_reg", m_reg[h], commit_reg);
            check_value(r.name, "commit_data", m_data[h], commit_data);
        end
        if (e_flush) check_value(r.name, "flush_pc", m_pc[h], flush_pc);
        if (e_rel) check_value(r.name, "store_tag", 32'(h), store_tag);
        // state after the clock edge
        if (e_flush) begin
            q.delete();
            m_tail = 0;
            m_state = 0;
        end else begin
            m_state = nxt;
            if (e_retire) void'(q.pop_front());
            if (alloc && !e_full) begin
                q.push_back(m_tail);
                m_done[m_tail] = 1'b0;
                m_store[m_tail] = r.st;
                m_pred[m_tail] = r.tk;
                m_reg[m_tail] = r.rd;
                m_tail = (m_tail + 1) % 8;
            end
            if (cdb_valid) begin
                m_done[r.tag] = 1'b1;
                m_act[r.tag] = r.tk;
                m_data[r.tag] = d;
                m_pc[r.tag] = jump_target(r.tag);
            end
        end
    endtask

    task automatic build_table();
        add_row(op_idle, 0, 0, 0, 0, "reset");
        for (int i = 0; i < 4; i++) add_row(op_alloc, i + 1, 0, 0, 0, "order_alloc");
        for (int i = 3; i >= 0; i--) add_row(op_complete, 0, 0, 0, i, "order_complete");
        for (int i = 0; i < 4; i++) add_row(op_idle, 0, 0, 0, 0, "order_retire");
        // ninth alloc lands on a full buffer
        for (int i = 0; i < 9; i++) add_row(op_alloc, i + 5, 0, 0, 0, "full_alloc");
        add_row(op_complete, 0, 0, 0, 4, "full_complete");
        add_row(op_idle, 0, 0, 0, 0, "full_retire");
        add_row(op_alloc, 20, 0, 0, 0, "full_wrap");
        for (int i = 5; i < 13; i++) add_row(op_complete, 0, 0, 0, i % 8, "full_drain");
        for (int i = 0; i < 2; i++) add_row(op_idle, 0, 0, 0, 0, "full_drain");
        add_row(op_alloc, 0, 1, 0, 0, "store_alloc");
        add_row(op_wait, 0, 0, 0, 0, "store_release");
        add_row(op_alloc, 21, 0, 0, 0, "store_younger");
        add_row(op_alloc, 22, 0, 0, 0, "store_younger");
        add_row(op_complete, 0, 0, 0, 6, "store_younger");
        add_row(op_complete, 0, 0, 0, 7, "store_younger");
        for (int i = 0; i < 3; i++) add_row(op_idle, 0, 0, 0, 0, "store_hold");
        add_row(op_sdone, 0, 0, 0, 0, "store_done");
        for (int i = 0; i < 2; i++) add_row(op_idle, 0, 0, 0, 0, "store_drain");
        add_row(op_alloc, 12, 0, 0, 0, "branch_alloc");
        add_row(op_alloc, 13, 0, 0, 0, "branch_younger");
        add_row(op_alloc, 14, 0, 0, 0, "branch_younger");
        add_row(op_complete, 0, 0, 0, 2, "branch_younger");
        add_row(op_complete, 0, 0, 0, 1, "branch_younger");
        add_row(op_complete, 0, 0, 1, 0, "branch_resolve");
        // dispatch in the flush cycle is dropped
        add_row(op_alloc, 15, 0, 0, 0, "branch_flush");
        for (int i = 0; i < 2; i++) add_row(op_idle, 0, 0, 0, 0, "branch_empty");
        add_row(op_alloc, 16, 0, 0, 0, "branch_after");
        add_row(op_complete, 0, 0, 0, 0, "branch_after");
        for (int i = 0; i < 2; i++) add_row(op_idle, 0, 0, 0, 0, "branch_after");
    endtask

    initial begin
        int n;
        {rst, alloc, alloc_is_store, alloc_pred_taken, cdb_valid, cdb_taken, store_done} = 7'h40;
        alloc_reg = '0;
        cdb_tag = '0;
        cdb_data = '0;
        cdb_jump_pc = '0;
        build_table();
        repeat (8) @(posedge clk);
        #5;
        rst = 1'b0;
        foreach (rows[i]) begin
            if (rows[i].op == op_wait) begin
                n = 0;
                do begin
                    apply_row(rows[i]);
                    n++;
                end while (!store_release && n < 10);
                assert (store_release) else begin
                    errors++;
                    $display("store_release never came in %s", rows[i].name);
                end
            end else begin
                apply_row(rows[i]);
            end
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- src.f
source/rob_pkg.sv
source/cdb_if.sv
source/rob_head_if.sv
source/rob_ptr_ctrl.sv
source/rob_entry_file.sv
source/rob_commit_fsm.sv
source/rob_top.sv
tests/rob_tb.sv

//--- Bender.yml
package:
  name: rob

sources:
  - source/rob_pkg.sv
  - source/cdb_if.sv
  - source/rob_head_if.sv
  - source/rob_ptr_ctrl.sv
  - source/rob_entry_file.sv
  - source/rob_commit_fsm.sv
  - source/rob_top.sv
  - target: test
    files:
      - tests/rob_tb.sv
